/* fabric_config.svh */
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// Single-length tracks on each side of the tile
`define FAB_WS 4

// Logic slice geometry
`define FAB_NUM_LUTS 2
`define FAB_LUT_K 4

// Connection block picks one of the eight inbound track bits
`define FAB_CB_SEL_W 3

// Switch box picks one of sixteen sources
`define FAB_SB_SEL_W 4

// Host word shifted into the chain per handshake
`define FAB_CFG_WORD_W 16

`endif

/* fabric_cfg_pkg.sv */
`include "fabric_config.svh"

package fabric_cfg_pkg;

  localparam int LUT_TT_W = 1 << `FAB_LUT_K;
  localparam int LUT_PINS = `FAB_NUM_LUTS * `FAB_LUT_K;

  // Per LUT truth table indexed by its inputs and sync select for the flip-flop
  typedef struct packed {
    logic [LUT_TT_W-1:0] truth_table;
    logic                sync_sel;
  } lut_cfg_t;

  typedef struct packed {
    lut_cfg_t [`FAB_NUM_LUTS-1:0] lut;
  } slice_cfg_t;

  // One selector per LUT input pin
  typedef struct packed {
    logic [LUT_PINS-1:0][`FAB_CB_SEL_W-1:0] in_sel;
  } cb_cfg_t;

  // One selector per outbound track
  typedef struct packed {
    logic [`FAB_WS-1:0][`FAB_SB_SEL_W-1:0] north_sel;
    logic [`FAB_WS-1:0][`FAB_SB_SEL_W-1:0] east_sel;
  } sb_cfg_t;

  localparam int SLICE_CFG_LEN = $bits(slice_cfg_t);
  localparam int CB_CFG_LEN    = $bits(cb_cfg_t);
  localparam int SB_CFG_LEN    = $bits(sb_cfg_t);

  // Whole serial chain with the slice segment at the head
  localparam int CFG_CHAIN_LEN = SLICE_CFG_LEN + CB_CFG_LEN + SB_CFG_LEN;

endpackage

/* fabric_io_pkg.sv */
`include "fabric_config.svh"

package fabric_io_pkg;

  // Group of single-length tracks on one side
  typedef logic [`FAB_WS-1:0] track_t;

  // LUT input pins with LUT0 in the low nibble and bit 0 as address LSB
  typedef logic [`FAB_NUM_LUTS*`FAB_LUT_K-1:0] lut_in_t;

  // One output per LUT
  typedef logic [`FAB_NUM_LUTS-1:0] lut_out_t;

  // Source numbering shared by the connection block and the switch box
  localparam int SRC_WEST  = 0;
  localparam int SRC_SOUTH = SRC_WEST + `FAB_WS;
  localparam int SRC_LUT   = SRC_SOUTH + `FAB_WS;

  // Sources above the LUT outputs read as constant zero
  localparam int SRC_COUNT = 1 << `FAB_SB_SEL_W;

endpackage

/* slice_io_if.sv */
`timescale 1ns/1ns

interface slice_io_if;
  import fabric_io_pkg::*;

  lut_in_t  lut_in;
  lut_out_t lut_out;
  logic     carry_in;
  logic     carry_out;

  // Connection block feeds the LUT pins
  modport cb (output lut_in);

  modport slice (
    input  lut_in,
    input  carry_in,
    output lut_out,
    output carry_out
  );

  // Switch box routes the LUT outputs onto outbound tracks
  modport sb (input lut_out);

endinterface

/* cfg_shift_reg.sv */
`timescale 1ns/1ns

module cfg_shift_reg #(
  parameter type cfg_t = fabric_cfg_pkg::slice_cfg_t
) (
  input  logic clk,
  input  logic rst,
  input  logic shift,
  input  logic set,
  input  logic data_in,
  output logic data_out,
  output cfg_t cfg
);

  localparam int W = $bits(cfg_t);

  logic [W-1:0] shift_q;
  logic [W-1:0] active_q;

  // Bit 0 sits at the head and the oldest bit leaves from the top
  always_ff @(posedge clk) begin
    if (rst) begin
      shift_q <= '0;
    end else if (shift) begin
      shift_q <= {shift_q[W-2:0], data_in};
    end
  end

  // Shadow copy only goes live on set
  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= '0;
    end else if (set) begin
      active_q <= shift_q;
    end
  end

  assign data_out = shift_q[W-1];
  assign cfg      = cfg_t'(active_q);

  // Loader never commits a segment while it is still moving
  a_no_shift_during_set : assert property (
    @(posedge clk) disable iff (rst) !(shift && set)
  );

endmodule

/* cfg_loader.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module cfg_loader (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_req,
  input  logic                       cfg_last,
  input  logic [`FAB_CFG_WORD_W-1:0] cfg_word,
  output logic                       cfg_ack,
  output logic                       cfg_shift,
  output logic                       cfg_data,
  output logic                       cfg_set
);
  import fabric_cfg_pkg::*;

  localparam int WORD_W = `FAB_CFG_WORD_W;
  localparam int CNT_W  = $clog2(WORD_W);
  localparam int FILL_W = $clog2(CFG_CHAIN_LEN + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_SET,
    ST_ACK,
    ST_RELEASE
  } state_t;

  state_t            state;
  logic [CNT_W-1:0]  bit_cnt;
  logic [WORD_W-1:0] word_q;
  logic              last_q;
  logic              ack_q;
  logic              capture;
  logic [FILL_W-1:0] fill_cnt;

  // New word only once the previous ack has dropped
  assign capture = (state == ST_IDLE) && cfg_req && !ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      last_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (capture) begin
            state   <= ST_SHIFT;
            bit_cnt <= '0;
            last_q  <= cfg_last;
          end
        end
        ST_SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(WORD_W - 1)) begin
            state <= last_q ? ST_SET : ST_ACK;
          end
        end
        ST_SET:  state <= ST_ACK;
        ST_ACK: begin
          ack_q <= 1'b1;
          state <= ST_RELEASE;
        end
        ST_RELEASE: begin
          if (!cfg_req) begin
            ack_q <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // MSB leaves first
  always_ff @(posedge clk) begin
    if (capture) begin
      word_q <= cfg_word;
    end else if (state == ST_SHIFT) begin
      word_q <= {word_q[WORD_W-2:0], 1'b0};
    end
  end

  // Count of bits moved into the chain since the last commit up to the full length
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt <= '0;
    end else if (cfg_set) begin
      fill_cnt <= '0;
    end else if (cfg_shift && fill_cnt != FILL_W'(CFG_CHAIN_LEN)) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  assign cfg_shift = (state == ST_SHIFT);
  assign cfg_set   = (state == ST_SET);
  assign cfg_data  = word_q[WORD_W-1];
  assign cfg_ack   = ack_q;

  a_no_ack_while_shifting : assert property (
    @(posedge clk) disable iff (rst) !(cfg_ack && cfg_shift)
  );

  a_set_one_cycle : assert property (
    @(posedge clk) disable iff (rst) cfg_set |=> !cfg_set
  );

  // A commit needs a full chain of fresh bits behind it
  a_set_after_full_frame : assert property (
    @(posedge clk) disable iff (rst) cfg_set |-> fill_cnt == FILL_W'(CFG_CHAIN_LEN)
  );

endmodule

/* clb_slice.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module clb_slice (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cen,
  input  fabric_cfg_pkg::slice_cfg_t cfg,
  slice_io_if.slice                  pins
);
  import fabric_io_pkg::*;

  localparam int K = `FAB_LUT_K;

  lut_out_t lut_comb;
  lut_out_t lut_q;
  logic     carry_prop;
  logic     carry_gen;

  // Each LUT reads its truth table at the address on its own pin group
  always_comb begin
    for (int i = 0; i < `FAB_NUM_LUTS; i++) begin
      lut_comb[i] = cfg.lut[i].truth_table[pins.lut_in[i*K +: K]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lut_q <= '0;
    end else if (cen) begin
      lut_q <= lut_comb;
    end
  end

  // Sync select picks the flip-flop over the combinational result
  always_comb begin
    for (int i = 0; i < `FAB_NUM_LUTS; i++) begin
      pins.lut_out[i] = cfg.lut[i].sync_sel ? lut_q[i] : lut_comb[i];
    end
  end

  // One-bit carry stage with LUT0 as propagate and LUT1 as generate
  assign carry_prop     = lut_comb[0];
  assign carry_gen      = lut_comb[1];
  assign pins.carry_out = carry_prop ? pins.carry_in : carry_gen;

  // Output flip-flops hold whenever the clock enable is low
  a_ff_hold_without_cen : assert property (
    @(posedge clk) disable iff (rst) !cen |=> $stable(lut_q)
  );

endmodule

/* connection_block.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module connection_block (
  input  fabric_cfg_pkg::cb_cfg_t cfg,
  input  fabric_io_pkg::track_t   west_single,
  input  fabric_io_pkg::track_t   south_single,
  slice_io_if.cb                  pins
);
  import fabric_io_pkg::*;

  localparam int NUM_PINS    = $bits(lut_in_t);
  localparam int NUM_INBOUND = 1 << `FAB_CB_SEL_W;

  logic [NUM_INBOUND-1:0] inbound;
  lut_in_t                lut_sel;

  // Inbound bits follow the shared source numbering
  always_comb begin
    inbound = '0;
    inbound[SRC_WEST +: `FAB_WS]  = west_single;
    inbound[SRC_SOUTH +: `FAB_WS] = south_single;
  end

  // One selector per LUT pin
  always_comb begin
    for (int i = 0; i < NUM_PINS; i++) begin
      lut_sel[i] = inbound[cfg.in_sel[i]];
    end
  end

  assign pins.lut_in = lut_sel;

endmodule

/* switch_box.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module switch_box (
  input  fabric_cfg_pkg::sb_cfg_t cfg,
  input  fabric_io_pkg::track_t   west_single,
  input  fabric_io_pkg::track_t   south_single,
  slice_io_if.sb                  pins,
  output fabric_io_pkg::track_t   north_single,
  output fabric_io_pkg::track_t   east_single
);
  import fabric_io_pkg::*;

  logic [SRC_COUNT-1:0] sources;

  // Unused source numbers above the LUT outputs stay at zero
  always_comb begin
    sources = '0;
    sources[SRC_WEST +: `FAB_WS]         = west_single;
    sources[SRC_SOUTH +: `FAB_WS]        = south_single;
    sources[SRC_LUT +: `FAB_NUM_LUTS]    = pins.lut_out;
  end

  // North tracks
  always_comb begin
    for (int i = 0; i < `FAB_WS; i++) begin
      north_single[i] = sources[cfg.north_sel[i]];
    end
  end

  // East tracks
  always_comb begin
    for (int i = 0; i < `FAB_WS; i++) begin
      east_single[i] = sources[cfg.east_sel[i]];
    end
  end

endmodule

/* clb_tile.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module clb_tile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cen,
  input  logic [`FAB_WS-1:0]         west_single,
  input  logic [`FAB_WS-1:0]         south_single,
  output logic [`FAB_WS-1:0]         north_single,
  output logic [`FAB_WS-1:0]         east_single,
  input  logic                       carry_in,
  output logic                       carry_out,
  input  logic                       cfg_req,
  input  logic                       cfg_last,
  input  logic [`FAB_CFG_WORD_W-1:0] cfg_word,
  output logic                       cfg_ack,
  output logic                       chain_out
);
  import fabric_cfg_pkg::*;

  // Chain order is loader, slice, connection block, switch box
  logic cfg_shift;
  logic cfg_set;
  logic chain_head;
  logic slice_so;
  logic cb_so;

  slice_cfg_t slice_cfg;
  cb_cfg_t    cb_cfg;
  sb_cfg_t    sb_cfg;

  slice_io_if pins_if ();

  // Carry runs straight through the tile boundary
  assign pins_if.carry_in = carry_in;
  assign carry_out        = pins_if.carry_out;

  cfg_loader loader_i (
    .clk       (clk),
    .rst       (rst),
    .cfg_req   (cfg_req),
    .cfg_last  (cfg_last),
    .cfg_word  (cfg_word),
    .cfg_ack   (cfg_ack),
    .cfg_shift (cfg_shift),
    .cfg_data  (chain_head),
    .cfg_set   (cfg_set)
  );

  cfg_shift_reg #(.cfg_t(slice_cfg_t)) slice_cfg_i (
    .clk      (clk),
    .rst      (rst),
    .shift    (cfg_shift),
    .set      (cfg_set),
    .data_in  (chain_head),
    .data_out (slice_so),
    .cfg      (slice_cfg)
  );

  cfg_shift_reg #(.cfg_t(cb_cfg_t)) cb_cfg_i (
    .clk      (clk),
    .rst      (rst),
    .shift    (cfg_shift),
    .set      (cfg_set),
    .data_in  (slice_so),
    .data_out (cb_so),
    .cfg      (cb_cfg)
  );

  cfg_shift_reg #(.cfg_t(sb_cfg_t)) sb_cfg_i (
    .clk      (clk),
    .rst      (rst),
    .shift    (cfg_shift),
    .set      (cfg_set),
    .data_in  (cb_so),
    .data_out (chain_out),
    .cfg      (sb_cfg)
  );

  clb_slice slice_i (
    .clk  (clk),
    .rst  (rst),
    .cen  (cen),
    .cfg  (slice_cfg),
    .pins (pins_if)
  );

  connection_block cb_i (
    .cfg          (cb_cfg),
    .west_single  (west_single),
    .south_single (south_single),
    .pins         (pins_if)
  );

  switch_box sb_i (
    .cfg          (sb_cfg),
    .west_single  (west_single),
    .south_single (south_single),
    .pins         (pins_if),
    .north_single (north_single),
    .east_single  (east_single)
  );

endmodule

/* tb_clb_tile.sv */
`timescale 1ns/1ns
`include "fabric_config.svh"

module tb_clb_tile;
  import fabric_cfg_pkg::*;
  import fabric_io_pkg::*;

  localparam int FRAME_W = CFG_CHAIN_LEN;
  localparam int WORD_W  = `FAB_CFG_WORD_W;
  localparam int WORDS   = (FRAME_W + WORD_W - 1) / WORD_W;
  localparam int PAD_W   = WORDS * WORD_W - FRAME_W;
  localparam int TIMEOUT = 40;

  logic               clk;
  logic               rst;
  logic               cen;
  logic [`FAB_WS-1:0] west_single;
  logic [`FAB_WS-1:0] south_single;
  logic [`FAB_WS-1:0] north_single;
  logic [`FAB_WS-1:0] east_single;
  logic               carry_in;
  logic               carry_out;
  logic               cfg_req;
  logic               cfg_last;
  logic [WORD_W-1:0]  cfg_word;
  logic               cfg_ack;
  logic               chain_out;

  // Reference model of the active configuration and the LUT flip-flops
  slice_cfg_t m_slice;
  cb_cfg_t    m_cb;
  sb_cfg_t    m_sb;
  lut_out_t   m_ff;

  logic [FRAME_W-1:0] prev_frame;
  logic [FRAME_W-1:0] frame;
  int                 errors;
  int                 checks;
  int                 tests;
  int                 errors_at_start;
  bit                 record_chain;
  logic               chain_bits[$];

  clb_tile clb_tile_i (
    .clk          (clk),
    .rst          (rst),
    .cen          (cen),
    .west_single  (west_single),
    .south_single (south_single),
    .north_single (north_single),
    .east_single  (east_single),
    .carry_in     (carry_in),
    .carry_out    (carry_out),
    .cfg_req      (cfg_req),
    .cfg_last     (cfg_last),
    .cfg_word     (cfg_word),
    .cfg_ack      (cfg_ack),
    .chain_out    (chain_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $finish;
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
    end
  endtask

  // Reference tile with west as sources 0 to 3, south as 4 to 7 and the LUTs as 8 and 9
  function automatic void model_eval(input track_t w, input track_t s, input logic ci,
                                     output track_t n, output track_t e, output logic co,
                                     output lut_out_t comb);
    logic [7:0]  inbound;
    lut_in_t     pin;
    lut_out_t    lut_o;
    logic [15:0] src;
    inbound = {s, w};
    for (int p = 0; p < 8; p++) begin
      pin[p] = inbound[m_cb.in_sel[p]];
    end
    comb[0] = m_slice.lut[0].truth_table[pin[3:0]];
    comb[1] = m_slice.lut[1].truth_table[pin[7:4]];
    for (int i = 0; i < 2; i++) begin
      lut_o[i] = m_slice.lut[i].sync_sel ? m_ff[i] : comb[i];
    end
    src = {6'b0, lut_o, s, w};
    for (int i = 0; i < 4; i++) begin
      n[i] = src[m_sb.north_sel[i]];
      e[i] = src[m_sb.east_sel[i]];
    end
    co = comb[0] ? ci : comb[1];
  endfunction

  function automatic logic [FRAME_W-1:0] random_frame();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[FRAME_W-1:0];
  endfunction

  // Frame layout is {switch box, connection block, slice} with slice bit 0 last in
  task automatic load_model(input logic [FRAME_W-1:0] f);
    m_slice = f[SLICE_CFG_LEN-1:0];
    m_cb    = f[SLICE_CFG_LEN +: CB_CFG_LEN];
    m_sb    = f[SLICE_CFG_LEN+CB_CFG_LEN +: SB_CFG_LEN];
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic drive_and_check(input logic cen_val);
    track_t   exp_n;
    track_t   exp_e;
    logic     exp_c;
    lut_out_t comb;
    west_single  = $urandom_range(15, 0);
    south_single = $urandom_range(15, 0);
    carry_in     = $urandom_range(1, 0);
    cen          = cen_val;
    #1;
    model_eval(west_single, south_single, carry_in, exp_n, exp_e, exp_c, comb);
    checks++;
    if (north_single !== exp_n || east_single !== exp_e || carry_out !== exp_c) begin
      report_error($sformatf("north=%h east=%h carry=%b, expected north=%h east=%h carry=%b",
                             north_single, east_single, carry_out, exp_n, exp_e, exp_c));
    end
    if (cen_val) begin
      m_ff = comb;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_word(input logic [WORD_W-1:0] w, input logic last);
    int cyc;
    checks++;
    if (cfg_ack !== 1'b0) begin
      report_error("cfg_ack high before cfg_req was raised");
    end
    cfg_word = w;
    cfg_last = last;
    cfg_req  = 1'b1;
    cyc      = 0;
    // The first edge counted is the capture edge and each sample precedes a shift
    while (cfg_ack !== 1'b1 && cyc < TIMEOUT) begin
      @(posedge clk);
      #1;
      if (record_chain && cyc < WORD_W) begin
        chain_bits.push_back(chain_out);
      end
      cyc++;
    end
    if (cfg_ack !== 1'b1) begin
      abort_run("Timeout: cfg_ack did not rise within 40 cycles of cfg_req");
    end else begin
      checks++;
      if (cyc != (last ? WORD_W + 3 : WORD_W + 2)) begin
        report_error($sformatf("cfg_ack rose %0d cycles after capture", cyc - 1));
      end
      cfg_req = 1'b0;
      cyc     = 0;
      while (cfg_ack !== 1'b0 && cyc < TIMEOUT) begin
        @(posedge clk);
        #1;
        cyc++;
      end
      if (cfg_ack !== 1'b0) begin
        abort_run("Timeout: cfg_ack did not fall after cfg_req was dropped");
      end else begin
        checks++;
        if (cyc != 1) begin
          report_error($sformatf("cfg_ack fell %0d cycles after cfg_req fell", cyc));
        end
      end
    end
  endtask

  // Filler bits go first and fall off the tail
  task automatic send_frame(input logic [FRAME_W-1:0] f, input bit check_between);
    logic [WORDS*WORD_W-1:0] padded;
    padded = {PAD_W'($urandom), f};
    for (int i = 0; i < WORDS; i++) begin
      send_word(padded[(WORDS-1-i)*WORD_W +: WORD_W], i == WORDS - 1);
      if (check_between && i < WORDS - 1) begin
        drive_and_check(1'b0);
        drive_and_check(1'b0);
      end
    end
  endtask

  initial begin
    slice_cfg_t s_cfg;
    sb_cfg_t    b_cfg;
    void'($urandom(32'h33bc5863));
    rst          = 1'b1;
    cen          = 1'b0;
    west_single  = '0;
    south_single = '0;
    carry_in     = 1'b0;
    cfg_req      = 1'b0;
    cfg_last     = 1'b0;
    cfg_word     = '0;
    record_chain = 1'b0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    m_slice      = '0;
    m_cb         = '0;
    m_sb         = '0;
    m_ff         = '0;
    prev_frame   = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test();
    checks++;
    if (cfg_ack !== 1'b0) begin
      report_error("cfg_ack high after reset");
    end
    repeat (10) drive_and_check(1'b0);
    end_test("reset state");

    begin_test();
    frame = random_frame();
    send_frame(frame, 1'b0);
    load_model(frame);
    end_test("handshake");

    // Sync selects off so every LUT output is combinational
    begin_test();
    repeat (20) begin
      frame = random_frame();
      s_cfg = frame[SLICE_CFG_LEN-1:0];
      s_cfg.lut[0].sync_sel = 1'b0;
      s_cfg.lut[1].sync_sel = 1'b0;
      frame[SLICE_CFG_LEN-1:0] = s_cfg;
      send_frame(frame, 1'b0);
      load_model(frame);
      repeat (5) drive_and_check(1'b0);
    end
    end_test("random configurations");

    // Sync selects on and LUT outputs routed to the first north and east tracks
    begin_test();
    repeat (3) begin
      frame = random_frame();
      s_cfg = frame[SLICE_CFG_LEN-1:0];
      b_cfg = frame[SLICE_CFG_LEN+CB_CFG_LEN +: SB_CFG_LEN];
      s_cfg.lut[0].sync_sel = 1'b1;
      s_cfg.lut[1].sync_sel = 1'b1;
      b_cfg.north_sel[0] = 4'(SRC_LUT);
      b_cfg.east_sel[0]  = 4'(SRC_LUT + 1);
      frame = {b_cfg, frame[SLICE_CFG_LEN +: CB_CFG_LEN], s_cfg};
      send_frame(frame, 1'b0);
      load_model(frame);
      repeat (20) drive_and_check($urandom_range(1, 0));
      cen = 1'b0;
    end
    end_test("registered outputs");

    begin_test();
    frame = random_frame();
    send_frame(frame, 1'b1);
    load_model(frame);
    repeat (5) drive_and_check(1'b0);
    prev_frame = frame;
    end_test("shadow configuration");

    begin_test();
    chain_bits.delete();
    record_chain = 1'b1;
    frame = random_frame();
    send_frame(frame, 1'b0);
    record_chain = 1'b0;
    load_model(frame);
    checks++;
    if (chain_bits.size() < FRAME_W) begin
      report_error($sformatf("only %0d bits seen on chain_out", chain_bits.size()));
    end else begin
      for (int k = 0; k < FRAME_W; k++) begin
        checks++;
        if (chain_bits[k] !== prev_frame[FRAME_W-1-k]) begin
          report_error($sformatf("chain_out bit %0d is %b, expected %b",
                                 k, chain_bits[k], prev_frame[FRAME_W-1-k]));
        end
      end
    end
    end_test("chain output");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
fabric_cfg_pkg.sv
fabric_io_pkg.sv
slice_io_if.sv
cfg_shift_reg.sv
cfg_loader.sv
clb_slice.sv
connection_block.sv
switch_box.sv
clb_tile.sv
tb_clb_tile.sv
